// ==== audio_codec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "audio_macros.svh"

module audio_codec_top (
    input  wire         clk_soc,
    input  wire         btn_rst,
    input  wire [3:0]   wb_adr_i,
    input  wire [31:0]  wb_dat_i,
    input  wire [3:0]   wb_sel_i,
    input  wire         wb_we_i,
    input  wire         wb_stb_i,
    output wire [31:0]  wb_dat_o,
    output wire         wb_ack_o,
    output wire         ac_cdata_o,
    output wire         ac_cclk_o,
    output wire         ac_clatch_n_o,
    output wire         ac_bclk_o,
    output wire         ac_lrclk_o,
    output wire         ac_sdata_o,
    output wire         init_done_o
);
    import audio_pkg::*;

    wire                cmd_req;                  // sequencer to spi handshake
    wire                cmd_ack;
    codec_cmd_t         cmd_data;
    wire [`NUM_CH-1:0]  fifo_push;
    wire [`NUM_CH-1:0]  fifo_full;
    wire [`NUM_CH-1:0]  fifo_empty;
    audio_sample_t      fifo_wdata;               // shared by both channels
    audio_sample_t      fifo_rdata [`NUM_CH];
    wire                pop;                      // one pop for the stereo pair

    codec_cmd_list i_codec_cmd_list (
        .clk_soc     (clk_soc),
        .btn_rst     (btn_rst),
        .cmd_req_o   (cmd_req),
        .cmd_data_o  (cmd_data),
        .cmd_ack_i   (cmd_ack),
        .init_done_o (init_done_o)
    );

    codec_spi_master i_codec_spi_master (
        .clk_soc    (clk_soc),
        .btn_rst    (btn_rst),
        .cmd_req_i  (cmd_req),
        .cmd_data_i (cmd_data),
        .cmd_ack_o  (cmd_ack),
        .cdata_o    (ac_cdata_o),
        .cclk_o     (ac_cclk_o),
        .clatch_n_o (ac_clatch_n_o)
    );

    wb_audio_regs i_wb_audio_regs (
        .clk_soc      (clk_soc),
        .btn_rst      (btn_rst),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_we_i      (wb_we_i),
        .wb_stb_i     (wb_stb_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .init_done_i  (init_done_o),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .fifo_push_o  (fifo_push),
        .fifo_wdata_o (fifo_wdata)
    );

    for (genvar ch = 0; ch < `NUM_CH; ch++) begin : g_fifo   // 0 left, 1 right
        sample_fifo i_sample_fifo (
            .clk_soc (clk_soc),
            .btn_rst (btn_rst),
            .push_i  (fifo_push[ch]),
            .wdata_i (fifo_wdata),
            .pop_i   (pop),
            .rdata_o (fifo_rdata[ch]),
            .full_o  (fifo_full[ch]),
            .empty_o (fifo_empty[ch])
        );
    end

    i2s_tx i_i2s_tx (
        .clk_soc     (clk_soc),
        .btn_rst     (btn_rst),
        .enable_i    (init_done_o),               // silent until the codec is set up
        .left_i      (fifo_rdata[0]),
        .right_i     (fifo_rdata[1]),
        .any_empty_i (fifo_empty),
        .pop_o       (pop),
        .bclk_o      (ac_bclk_o),
        .lrclk_o     (ac_lrclk_o),
        .sdata_o     (ac_sdata_o)
    );

endmodule

`default_nettype wire

// ==== audio_macros.svh ====
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// channel FIFOs
`define FIFO_DEPTH      8         // entries per channel
`define FIFO_AW         3         // log2 of FIFO_DEPTH

// serial clocks derived from clk_soc
`define CCLK_DIV        4         // clk_soc cycles per cclk half period
`define BCLK_DIV        2         // clk_soc cycles per bclk half period

// codec power-up sequence
`define CODEC_CMD_COUNT 6         // words in codec_init_table

// bus register map, byte offsets
`define REG_LEFT        4'h0      // left sample write
`define REG_RIGHT       4'h4      // right sample write
`define REG_STATUS      4'h8      // init and fifo flags

`define NUM_CH          2         // left and right

`endif

// ==== audio_pkg.sv ====
`default_nettype none

`include "audio_macros.svh"

package audio_pkg;

    typedef logic signed [23:0] audio_sample_t;   // one pcm sample
    typedef logic [31:0]        codec_cmd_t;      // chip addr, reg addr, data byte

    // adau style write words {8'h00 write, 16'h reg, 8'h value}
    parameter codec_cmd_t codec_init_table [`CODEC_CMD_COUNT] = '{
        32'h0040_0001,                            // clock control, core clock on
        32'h0040_1C21,                            // mixer3, left dac to left mixer
        32'h0040_1E41,                            // mixer4, right dac to right mixer
        32'h0040_2903,                            // playback power, both channels up
        32'h0040_2A03,                            // dac control, both dacs on
        32'h0040_F97F                             // clock enable 0, all blocks on
    };

endpackage

`default_nettype wire

// ==== codec_cmd_list.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "audio_macros.svh"

module codec_cmd_list (
    input  wire                     clk_soc,
    input  wire                     btn_rst,
    output logic                    cmd_req_o,
    output audio_pkg::codec_cmd_t   cmd_data_o,
    input  wire                     cmd_ack_i,
    output logic                    init_done_o
);
    import audio_pkg::*;

    localparam int unsigned IDX_W = $clog2(`CODEC_CMD_COUNT);

    typedef enum logic [1:0] {
        ST_IDLE,                                  // first cycle out of reset
        ST_REQ,                                   // req high, waiting for ack
        ST_REL,                                   // req dropped, waiting for ack low
        ST_DONE                                   // whole table sent
    } state_t;

    state_t           state_q;
    logic [IDX_W-1:0] idx_q;                      // current table entry

    assign cmd_data_o = codec_init_table[idx_q];  // stable while idx holds

    always_ff @(posedge clk_soc) begin
        if (btn_rst) begin
            state_q     <= ST_IDLE;
            idx_q       <= '0;
            cmd_req_o   <= 1'b0;
            init_done_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    cmd_req_o <= 1'b1;            // word 0 goes out
                    state_q   <= ST_REQ;
                end
                ST_REQ: begin
                    if (cmd_ack_i) begin
                        cmd_req_o <= 1'b0;        // phase 3
                        state_q   <= ST_REL;
                    end
                end
                ST_REL: begin
                    if (!cmd_ack_i) begin         // phase 4 seen
                        if (idx_q == IDX_W'(`CODEC_CMD_COUNT - 1)) begin
                            init_done_o <= 1'b1;
                            state_q     <= ST_DONE;
                        end else begin
                            idx_q     <= idx_q + 1'b1;
                            cmd_req_o <= 1'b1;    // next word
                            state_q   <= ST_REQ;
                        end
                    end
                end
                default: begin
                    state_q <= ST_DONE;           // init_done stays high
                end
            endcase
        end
    end

    // the spi master must still be acking when the sequencer lets go of req
    a_req_falls_on_ack: assert property (@(posedge clk_soc) disable iff (btn_rst)
        $fell(cmd_req_o) |-> cmd_ack_i);

endmodule

`default_nettype wire

// ==== codec_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "audio_macros.svh"

module codec_spi_master (
    input  wire                        clk_soc,
    input  wire                        btn_rst,
    input  wire                        cmd_req_i,
    input  wire audio_pkg::codec_cmd_t cmd_data_i,
    output logic                       cmd_ack_o,
    output logic                       cdata_o,
    output logic                       cclk_o,
    output logic                       clatch_n_o
);
    import audio_pkg::*;

    localparam int unsigned DIV_W = (`CCLK_DIV > 1) ? $clog2(`CCLK_DIV) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,                                 // latch low, bits going out
        ST_FIN,                                   // latch back high
        ST_HOLD                                   // ack high until req drops
    } state_t;

    state_t           state_q;
    logic [DIV_W-1:0] div_q;                      // cclk half period counter
    logic [4:0]       bit_q;                      // bits already sent
    codec_cmd_t       shift_q;                    // msb drives cdata
    logic             tick;

    assign tick    = (div_q == DIV_W'(`CCLK_DIV - 1));
    assign cdata_o = shift_q[31] & ~clatch_n_o;   // line idles low outside a word

    always_ff @(posedge clk_soc) begin
        if (btn_rst) begin
            state_q    <= ST_IDLE;
            div_q      <= '0;
            bit_q      <= '0;
            cmd_ack_o  <= 1'b0;
            cclk_o     <= 1'b0;
            clatch_n_o <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (cmd_req_i) begin
                        shift_q    <= cmd_data_i; // bit 31 valid right away
                        clatch_n_o <= 1'b0;
                        div_q      <= '0;
                        bit_q      <= '0;
                        state_q    <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    if (tick) begin
                        div_q  <= '0;
                        cclk_o <= ~cclk_o;
                        if (cclk_o) begin         // falling edge, data moves
                            if (bit_q == 5'd31) begin
                                clatch_n_o <= 1'b1;
                                state_q    <= ST_FIN;
                            end else begin
                                shift_q <= {shift_q[30:0], 1'b0};
                                bit_q   <= bit_q + 1'b1;
                            end
                        end
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                ST_FIN: begin
                    cmd_ack_o <= 1'b1;            // one cycle after latch rises
                    state_q   <= ST_HOLD;
                end
                default: begin
                    if (!cmd_req_i) begin
                        cmd_ack_o <= 1'b0;
                        state_q   <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // the sequencer must not change the word it is offering
    a_data_stable: assert property (@(posedge clk_soc) disable iff (btn_rst)
        (cmd_req_i && !cmd_ack_o) ##1 (cmd_req_i && !cmd_ack_o) |-> $stable(cmd_data_i));

endmodule

`default_nettype wire

// ==== i2s_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "audio_macros.svh"

module i2s_tx (
    input  wire                           clk_soc,
    input  wire                           btn_rst,
    input  wire                           enable_i,
    input  wire audio_pkg::audio_sample_t left_i,
    input  wire audio_pkg::audio_sample_t right_i,
    input  wire [`NUM_CH-1:0]             any_empty_i,
    output logic                          pop_o,
    output logic                          bclk_o,
    output logic                          lrclk_o,
    output logic                          sdata_o
);
    localparam int unsigned DIV_W = (`BCLK_DIV > 1) ? $clog2(`BCLK_DIV) : 1;

    logic [DIV_W-1:0] div_q;                      // bclk half period counter
    logic             bclk_q;
    logic             run_q;                      // frames are going out
    logic [5:0]       slot_q;                     // bit slot in the frame
    logic [63:0]      frame_q;                    // msb is the current slot
    logic             tick;
    logic             bclk_fall;
    logic             frame_start;
    logic             underrun;

    assign tick        = (div_q == DIV_W'(`BCLK_DIV - 1));
    assign bclk_fall   = run_q && tick && bclk_q;
    assign frame_start = enable_i && (!run_q || (bclk_fall && slot_q == 6'd63));
    assign underrun    = |any_empty_i;            // either channel dry
    assign pop_o       = frame_start && !underrun;
    assign bclk_o      = bclk_q;
    assign lrclk_o     = slot_q[5];               // high for slots 32..63
    assign sdata_o     = run_q && frame_q[63];

    always_ff @(posedge clk_soc) begin
        if (btn_rst || !enable_i) begin
            div_q  <= '0;
            bclk_q <= 1'b0;
            run_q  <= 1'b0;
            slot_q <= '0;
        end else if (!run_q) begin
            run_q <= 1'b1;                        // first frame loads now
        end else begin
            if (tick) begin
                div_q  <= '0;
                bclk_q <= ~bclk_q;
            end else begin
                div_q <= div_q + 1'b1;
            end
            if (bclk_fall) begin
                slot_q <= slot_q + 1'b1;          // 63 wraps to 0
            end
        end
    end

    // one slot of i2s delay ahead of each msb, 7 zero bits after each lsb
    always_ff @(posedge clk_soc) begin
        if (frame_start) begin
            frame_q <= underrun ? 64'h0 : {1'b0, left_i, 7'h0, 1'b0, right_i, 7'h0};
        end else if (bclk_fall) begin
            frame_q <= {frame_q[62:0], 1'b0};     // sdata moves on falling bclk
        end
    end

endmodule

`default_nettype wire

// ==== sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "audio_macros.svh"

module sample_fifo (
    input  wire                           clk_soc,
    input  wire                           btn_rst,
    input  wire                           push_i,
    input  wire audio_pkg::audio_sample_t wdata_i,
    input  wire                           pop_i,
    output audio_pkg::audio_sample_t      rdata_o,
    output logic                          full_o,
    output logic                          empty_o
);
    import audio_pkg::*;

    audio_sample_t       mem_q [`FIFO_DEPTH];     // sample storage
    logic [`FIFO_AW-1:0] wr_ptr_q;
    logic [`FIFO_AW-1:0] rd_ptr_q;
    logic [`FIFO_AW:0]   count_q;                 // occupancy
    logic                wr_en;
    logic                rd_en;

    assign wr_en   = push_i && !full_o;
    assign rd_en   = pop_i && !empty_o;
    assign full_o  = (count_q == `FIFO_DEPTH);
    assign empty_o = (count_q == '0);
    assign rdata_o = mem_q[rd_ptr_q];             // head word, fall through

    always_ff @(posedge clk_soc) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    always_ff @(posedge clk_soc) begin
        if (btn_rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;      // wraps at depth
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + wr_en - rd_en;
        end
    end

    // the register block and the i2s side must respect the flags
    a_no_overflow: assert property (@(posedge clk_soc) disable iff (btn_rst)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk_soc) disable iff (btn_rst)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
audio_pkg.sv
codec_cmd_list.sv
codec_spi_master.sv
wb_audio_regs.sv
sample_fifo.sv
i2s_tx.sv
audio_codec_top.sv
tb_audio_codec_top.sv

// ==== tb_audio_codec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "audio_macros.svh"

module tb_audio_codec_top;
    import audio_pkg::*;

    logic          clk_soc;
    logic          btn_rst;
    logic [3:0]    wb_adr_i;
    logic [31:0]   wb_dat_i;
    logic [3:0]    wb_sel_i;
    logic          wb_we_i;
    logic          wb_stb_i;
    logic [31:0]   wb_dat_o;
    logic          wb_ack_o;
    logic          ac_cdata_o;                        // codec control port
    logic          ac_cclk_o;
    logic          ac_clatch_n_o;
    logic          ac_bclk_o;                         // i2s side
    logic          ac_lrclk_o;
    logic          ac_sdata_o;
    logic          init_done_o;

    int            err_count    = 0;
    int            errs_before  = 0;                  // errors at start of current test
    int            tests_run    = 0;
    int            tests_failed = 0;
    logic [31:0]   rng          = 32'ha0029740;       // xorshift state
    logic [31:0]   spi_word     = '0;                 // bits of the word on cdata
    int            spi_bits     = 0;
    int            spi_words    = 0;                  // complete control words seen
    logic [63:0]   frame_bits   = '0;                 // i2s frame, first slot ends at msb
    logic [5:0]    slot_cnt     = '0;
    int            zero_frames  = 0;                  // silent frames received
    audio_sample_t exp_left [$];                      // samples still due on sdata
    audio_sample_t exp_right [$];
    logic [31:0]   rd;

    audio_codec_top i_audio_codec_top (.*);

    initial begin
        clk_soc = 1'b0;
        forever #2 clk_soc = ~clk_soc;                // 4 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic flag_error(input string msg);
        err_count++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic give_up(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count != errs_before) tests_failed++;
        $display("test %-18s %s", name, (err_count == errs_before) ? "ok" : "failed");
        errs_before = err_count;
    endtask

    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                              output logic [31:0] q);
        int n;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = 4'hf;                              // all lanes
        wb_we_i  = we;
        wb_stb_i = 1'b1;
        n        = 0;
        do begin
            @(posedge clk_soc);
            #1;
            n++;
        end while (!wb_ack_o && n < 16);
        if (!wb_ack_o) give_up("wb_ack_o never came");
        q = wb_dat_o;                                 // read data valid with ack
        @(posedge clk_soc);                           // stb still high through the ack cycle
        #1;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(posedge clk_soc);                           // idle cycle between accesses
        #1;
    endtask

    task automatic write_sample(input int ch, input logic expect_out);
        audio_sample_t s;
        logic [31:0]   q;
        rng = xorshift32(rng);
        s   = rng[23:0] | 24'h1;                      // nonzero, so silence means underrun
        bus_access(1'b1, (ch == 0) ? `REG_LEFT : `REG_RIGHT, {8'h00, s}, q);
        if (expect_out && ch == 0) exp_left.push_back(s);
        if (expect_out && ch == 1) exp_right.push_back(s);
    endtask

    // wait until every written sample came out, then for some silent frames
    task automatic settle(input int quiet);
        int n;
        int base;
        base = zero_frames;
        for (n = 0; n < 30000; n++) begin
            if (exp_left.size() != 0 || exp_right.size() != 0) base = zero_frames;
            else if (zero_frames >= base + quiet) break;
            @(posedge clk_soc);
            #1;
        end
        if (n == 30000) give_up("i2s output stopped delivering frames");
    endtask

    task automatic check_frame(input logic [63:0] f);
        audio_sample_t l;
        audio_sample_t r;
        l = f[62:39];                                 // slot 0 is the i2s delay bit
        r = f[30:7];
        assert (f[63] == 1'b0 && f[38:31] == '0 && f[6:0] == '0)
            else flag_error($sformatf("frame %h has bits outside the sample slots", f));
        if (f == '0) begin
            zero_frames++;
        end else begin
            assert (exp_left.size() > 0 && exp_right.size() > 0)
                else flag_error($sformatf("frame %h arrived with no sample pending", f));
            if (exp_left.size() > 0 && exp_right.size() > 0) begin
                assert (l == exp_left[0])
                    else flag_error($sformatf("left got %h, expected %h", l, exp_left[0]));
                assert (r == exp_right[0])
                    else flag_error($sformatf("right got %h, expected %h", r, exp_right[0]));
                void'(exp_left.pop_front());
                void'(exp_right.pop_front());
            end
        end
    endtask

    // control port decoder, bits valid on cclk rise inside the latch window
    always @(posedge ac_cclk_o) begin
        if (!btn_rst && !ac_clatch_n_o) begin
            spi_word = {spi_word[30:0], ac_cdata_o};
            spi_bits++;
        end
    end

    always @(posedge ac_clatch_n_o) begin
        if (!btn_rst) begin
            assert (spi_bits == 32) else flag_error($sformatf("latch held %0d bits", spi_bits));
            assert (spi_words < `CODEC_CMD_COUNT) else flag_error("extra control word sent");
            if (spi_words < `CODEC_CMD_COUNT) begin
                assert (spi_word == codec_init_table[spi_words])
                    else flag_error($sformatf("control word %0d is %h", spi_words, spi_word));
            end
            spi_words++;
            spi_bits = 0;
        end
    end

    // i2s decoder, 64 bclk rises per frame
    always @(posedge ac_bclk_o) begin
        if (!btn_rst) begin
            assert (ac_lrclk_o == slot_cnt[5])
                else flag_error($sformatf("lrclk %b in slot %0d", ac_lrclk_o, slot_cnt));
            frame_bits = {frame_bits[62:0], ac_sdata_o};
            slot_cnt   = slot_cnt + 1'b1;
            if (slot_cnt == '0) check_frame(frame_bits);
        end
    end

    a_ack_next: assert property (@(posedge clk_soc) disable iff (btn_rst)
        (wb_stb_i && !wb_ack_o) |=> wb_ack_o) else flag_error("no wb_ack_o after stb");
    a_ack_single: assert property (@(posedge clk_soc) disable iff (btn_rst)
        wb_ack_o |=> !wb_ack_o) else flag_error("wb_ack_o high for two cycles");
    a_ack_cause: assert property (@(posedge clk_soc) disable iff (btn_rst)
        wb_ack_o |-> $past(wb_stb_i)) else flag_error("wb_ack_o without stb");
    a_quiet_early: assert property (@(posedge clk_soc) disable iff (btn_rst)
        !init_done_o |-> !(ac_bclk_o || ac_lrclk_o || ac_sdata_o))
        else flag_error("i2s lines active before init_done_o");
    a_done_last: assert property (@(posedge clk_soc) disable iff (btn_rst)
        $rose(init_done_o) |-> spi_words == `CODEC_CMD_COUNT)
        else flag_error("init_done_o rose before the whole table was sent");

    initial begin
        btn_rst  = 1'b1;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        wb_we_i  = 1'b0;
        wb_stb_i = 1'b0;
        repeat (8) @(posedge clk_soc);
        #1 btn_rst = 1'b0;

        for (int i = 0; i < 5000 && !init_done_o; i++) begin
            @(posedge clk_soc);
            #1;
        end
        if (!init_done_o) give_up("init_done_o never rose");
        bus_access(1'b0, `REG_STATUS, '0, rd);
        assert (rd[0] && spi_words == `CODEC_CMD_COUNT) else flag_error("init not complete");
        end_test("init sequence");
        end_test("idle before init");

        for (int i = 0; i < 6; i++) begin             // left then right, pair by pair
            write_sample(0, 1'b1);
            write_sample(1, 1'b1);
        end
        settle(1);
        end_test("sample path");

        settle(3);                                    // both fifos dry
        end_test("underrun");

        for (int i = 0; i < `FIFO_DEPTH + 2; i++) write_sample(0, i < `FIFO_DEPTH);
        bus_access(1'b0, `REG_STATUS, '0, rd);
        assert (rd[1] && rd[4]) else flag_error($sformatf("status %h after left overflow", rd));
        for (int i = 0; i < `FIFO_DEPTH; i++) write_sample(1, 1'b1);
        settle(2);
        bus_access(1'b0, `REG_STATUS, '0, rd);
        assert (rd[3] && rd[4] && !rd[1]) else flag_error($sformatf("status %h after drain", rd));
        end_test("overflow");
        end_test("bus timing");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== wb_audio_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "audio_macros.svh"

module wb_audio_regs (
    input  wire                       clk_soc,
    input  wire                       btn_rst,
    input  wire [3:0]                 wb_adr_i,
    input  wire [31:0]                wb_dat_i,
    input  wire [3:0]                 wb_sel_i,
    input  wire                       wb_we_i,
    input  wire                       wb_stb_i,
    output logic [31:0]               wb_dat_o,
    output logic                      wb_ack_o,
    input  wire                       init_done_i,
    input  wire [`NUM_CH-1:0]         fifo_full_i,
    input  wire [`NUM_CH-1:0]         fifo_empty_i,
    output logic [`NUM_CH-1:0]        fifo_push_o,
    output audio_pkg::audio_sample_t  fifo_wdata_o
);
    import audio_pkg::*;

    audio_sample_t       wdata_q;                 // sample held for the push cycle
    logic                req;
    logic                wr_ok;
    logic [`NUM_CH-1:0]  hit;
    logic [31:0]         status;

    assign req    = wb_stb_i && !wb_ack_o;        // new access this cycle
    assign wr_ok  = req && wb_we_i && (wb_sel_i[2:0] == 3'b111);
    assign status = {{(31 - 2 * `NUM_CH){1'b0}}, fifo_empty_i, fifo_full_i, init_done_i};
    assign fifo_wdata_o = wdata_q;

    always_comb begin
        hit    = '0;
        hit[0] = (wb_adr_i == `REG_LEFT);
        hit[1] = (wb_adr_i == `REG_RIGHT);
    end

    always_ff @(posedge clk_soc) begin
        if (btn_rst) begin
            wb_ack_o    <= 1'b0;
            fifo_push_o <= '0;
        end else begin
            wb_ack_o    <= req;                   // ack one clock after stb
            fifo_push_o <= hit & ~fifo_full_i & {`NUM_CH{wr_ok}};  // full drops the sample
        end
    end

    always_ff @(posedge clk_soc) begin
        if (wr_ok) begin
            wdata_q <= wb_dat_i[23:0];
        end
        if (req && !wb_we_i) begin
            wb_dat_o <= (wb_adr_i == `REG_STATUS) ? status : 32'h0;
        end
    end

    // no back to back acks even when the master keeps stb high
    a_ack_pulse: assert property (@(posedge clk_soc) disable iff (btn_rst)
        wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire
